// ==== source/div_cfg.svh ====
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// operand width, one machine word
`define DIV_XLEN 32

// prep stage + one cell per quotient bit + result stage
`define DIV_LATENCY (`DIV_XLEN + 2)

`endif

// ==== source/div_pkg.sv ====
`include "div_cfg.svh"

package div_pkg;

    typedef logic [`DIV_XLEN-1:0] xlen_t;    // one data word

    // request from the core
    typedef struct packed {
        xlen_t dividend;
        xlen_t divisor;
        logic  is_signed;                     // 0 for divu/remu
        logic  want_rem;                      // 0 selects the quotient
    } div_req_t;

    // per-operation tags, carried down the pipe
    typedef struct packed {
        logic  neg_quot;                      // operand signs differ
        logic  neg_rem;                       // dividend was negative
        logic  want_rem;
        logic  div_zero;
        xlen_t dividend_orig;                 // remainder result on /0
    } div_tag_t;

    // contents of one pipeline stage
    typedef struct packed {
        xlen_t    rem;                        // partial remainder
        xlen_t    shift;                      // dividend bits out, quotient bits in
        xlen_t    divisor;                    // absolute divisor
        div_tag_t tag;
    } div_stage_t;

endpackage

// ==== source/div_operand_prep.sv ====
`include "div_cfg.svh"

module div_operand_prep (
    input  logic                clk,
    input  logic                rstn,
    input  logic                in_valid,
    input  div_pkg::div_req_t   in_req,
    output logic                prep_valid,
    output div_pkg::div_stage_t prep_stage
);

    logic              a_neg;
    logic              b_neg;
    div_pkg::xlen_t    a_abs;
    div_pkg::xlen_t    b_abs;
    div_pkg::div_tag_t tag_d;

    always_comb begin
        a_neg = in_req.is_signed & in_req.dividend[`DIV_XLEN-1];
        b_neg = in_req.is_signed & in_req.divisor[`DIV_XLEN-1];

        a_abs = a_neg ? -in_req.dividend : in_req.dividend;    // 0x80000000 stays as is
        b_abs = b_neg ? -in_req.divisor : in_req.divisor;

        tag_d.neg_quot      = a_neg ^ b_neg;
        tag_d.neg_rem       = a_neg;                           // rem follows dividend sign
        tag_d.want_rem      = in_req.want_rem;
        tag_d.div_zero      = (in_req.divisor == '0);
        tag_d.dividend_orig = in_req.dividend;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prep_valid <= 1'b0;
        end else begin
            prep_valid <= in_valid;
        end
    end

    // payload only loads with a request
    always_ff @(posedge clk) begin
        if (in_valid) begin
            prep_stage.rem     <= '0;
            prep_stage.shift   <= a_abs;
            prep_stage.divisor <= b_abs;
            prep_stage.tag     <= tag_d;
        end
    end

    // the whole pipe relies on a clean valid from the core
    a_prep_valid_known: assert property (
        @(posedge clk) disable iff (!rstn)
        !$isunknown(prep_valid)
    ) else $error("prep_valid is unknown");

endmodule

// ==== source/div_cell.sv ====
`include "div_cfg.svh"

module div_cell (
    input  logic                clk,
    input  logic                rstn,
    input  logic                cell_valid_in,
    input  div_pkg::div_stage_t cell_in,
    output logic                cell_valid_out,
    output div_pkg::div_stage_t cell_out
);

    logic [`DIV_XLEN:0] rem_sh;        // one bit wider, keeps the carry
    logic [`DIV_XLEN:0] div_ext;
    logic [`DIV_XLEN:0] diff;
    logic               q_bit;
    div_pkg::xlen_t     rem_next;
    div_pkg::xlen_t     shift_next;

    always_comb begin
        rem_sh  = {cell_in.rem, cell_in.shift[`DIV_XLEN-1]};
        div_ext = {1'b0, cell_in.divisor};
        diff    = rem_sh - div_ext;
        q_bit   = (rem_sh >= div_ext);

        // restoring step, keep rem_sh when it is below the divisor
        if (q_bit) begin
            rem_next = diff[`DIV_XLEN-1:0];
        end else begin
            rem_next = rem_sh[`DIV_XLEN-1:0];
        end

        shift_next = {cell_in.shift[`DIV_XLEN-2:0], q_bit};   // quotient bit in at lsb
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cell_valid_out <= 1'b0;
        end else begin
            cell_valid_out <= cell_valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (cell_valid_in) begin
            cell_out.rem     <= rem_next;
            cell_out.shift   <= shift_next;
            cell_out.divisor <= cell_in.divisor;
            cell_out.tag     <= cell_in.tag;      // tags ride along
        end
    end

    // holds only if prep started this op with a zero partial remainder
    a_rem_below_divisor: assert property (
        @(posedge clk) disable iff (!rstn)
        (cell_valid_out && cell_out.divisor != '0) |-> (cell_out.rem < cell_out.divisor)
    ) else $error("partial remainder %h not below divisor %h",
                  cell_out.rem, cell_out.divisor);

endmodule

// ==== source/div_array.sv ====
`include "div_cfg.svh"

module div_array (
    input  logic                clk,
    input  logic                rstn,
    input  logic                prep_valid,
    input  div_pkg::div_stage_t prep_stage,
    output logic                arr_valid,
    output div_pkg::div_stage_t arr_stage
);

    // index 0 is the prep output, index XLEN the last cell
    logic [`DIV_XLEN:0]  valid_chain;
    div_pkg::div_stage_t stage_chain [`DIV_XLEN+1];

    assign valid_chain[0] = prep_valid;
    assign stage_chain[0] = prep_stage;

    // one cell per quotient bit, msb first
    genvar i;
    generate
        for (i = 0; i < `DIV_XLEN; i++) begin : g_cell
            div_cell u_cell (
                .clk            (clk),
                .rstn           (rstn),
                .cell_valid_in  (valid_chain[i]),
                .cell_in        (stage_chain[i]),
                .cell_valid_out (valid_chain[i+1]),
                .cell_out       (stage_chain[i+1])
            );
        end
    endgenerate

    // shift now holds the full unsigned quotient
    assign arr_valid = valid_chain[`DIV_XLEN];
    assign arr_stage = stage_chain[`DIV_XLEN];

endmodule

// ==== source/div_result_fix.sv ====
module div_result_fix (
    input  logic                clk,
    input  logic                rstn,
    input  logic                arr_valid,
    input  div_pkg::div_stage_t arr_stage,
    output logic                out_valid,
    output div_pkg::xlen_t      out_data
);

    div_pkg::xlen_t quot;
    div_pkg::xlen_t rem;
    div_pkg::xlen_t result;

    always_comb begin
        if (arr_stage.tag.neg_quot) begin
            quot = -arr_stage.shift;
        end else begin
            quot = arr_stage.shift;
        end

        if (arr_stage.tag.neg_rem) begin
            rem = -arr_stage.rem;
        end else begin
            rem = arr_stage.rem;
        end

        // riscv divide by zero, same for signed and unsigned
        if (arr_stage.tag.div_zero) begin
            quot = '1;
            rem  = arr_stage.tag.dividend_orig;
        end

        result = arr_stage.tag.want_rem ? rem : quot;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= arr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (arr_valid) begin
            out_data <= result;
        end
    end

endmodule

// ==== source/div_unit.sv ====
module div_unit (
    input  logic              clk,
    input  logic              rstn,
    input  logic              in_valid,
    input  div_pkg::div_req_t in_req,
    output logic              out_valid,
    output div_pkg::xlen_t    out_data
);

    logic                prep_valid;
    div_pkg::div_stage_t prep_stage;
    logic                arr_valid;
    div_pkg::div_stage_t arr_stage;

    // abs operands and tags, 1 cycle
    div_operand_prep u_prep (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .prep_valid (prep_valid),
        .prep_stage (prep_stage)
    );

    // one cycle per quotient bit
    div_array u_array (
        .clk        (clk),
        .rstn       (rstn),
        .prep_valid (prep_valid),
        .prep_stage (prep_stage),
        .arr_valid  (arr_valid),
        .arr_stage  (arr_stage)
    );

    // sign fix and result select, 1 cycle
    div_result_fix u_fix (
        .clk       (clk),
        .rstn      (rstn),
        .arr_valid (arr_valid),
        .arr_stage (arr_stage),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// ==== verif/div_clk_gen.sv ====
module div_clk_gen (
    output logic clk,
    output logic rstn
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 10;    // 20 ns clock
    localparam int RESET_CYCLES = 2;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);                  // release between edges
        rstn = 1'b1;
    end

endmodule

// ==== verif/tb_div_unit.sv ====
`include "div_cfg.svh"

module tb_div_unit;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RANDOM_COUNT = 200;

    logic              clk;
    logic              rstn;
    logic              in_valid;
    div_pkg::div_req_t in_req;
    logic              out_valid;
    div_pkg::xlen_t    out_data;

    div_pkg::div_req_t vec_req [$];
    div_pkg::xlen_t    vec_exp [$];
    div_pkg::xlen_t    exp_q [$];        // results still in flight
    int                issue_q [$];      // cycle each request was driven

    logic [31:0] lfsr_state    = 32'h6567_4632;
    int          cycle_count   = 0;
    int          timeout_limit = 0;
    int          results_seen  = 0;

    div_clk_gen u_clk (
        .clk  (clk),
        .rstn (rstn)
    );

    div_unit u_dut (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input div_pkg::xlen_t got,
                              input div_pkg::xlen_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h (result %0d)",
                     name, got, exp, results_seen);
            abort_run();
        end
    endtask

    task automatic check_latency(input int got);
        if (got != `DIV_LATENCY) begin
            $display("Mismatch latency: got %h, expected %h (result %0d)",
                     got, `DIV_LATENCY, results_seen);
            abort_run();
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // riscv div/rem rules
    function automatic div_pkg::xlen_t ref_result(input div_pkg::div_req_t r);
        logic signed [`DIV_XLEN-1:0] a;
        logic signed [`DIV_XLEN-1:0] b;
        div_pkg::xlen_t              q;
        div_pkg::xlen_t              m;
        a = r.dividend;
        b = r.divisor;
        if (r.divisor == '0) begin
            q = '1;
            m = r.dividend;
        end else if (!r.is_signed) begin
            q = r.dividend / r.divisor;
            m = r.dividend % r.divisor;
        end else if (r.dividend == {1'b1, {(`DIV_XLEN-1){1'b0}}} && r.divisor == '1) begin
            q = r.dividend;                  // overflow case
            m = '0;
        end else begin
            q = a / b;                       // truncates toward zero
            m = a % b;
        end
        return r.want_rem ? m : q;
    endfunction

    task automatic load_vectors();
        int                fd;
        int                n;
        string             line;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       s;
        logic [31:0]       w;
        logic [31:0]       e;
        div_pkg::div_req_t r;
        fd = $fopen("verif/div_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file verif/div_input.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 0 && line.substr(0, 0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h", a, b, s, w, e);
                if (n == 5) begin
                    r.dividend  = a;
                    r.divisor   = b;
                    r.is_signed = s[0];
                    r.want_rem  = w[0];
                    vec_req.push_back(r);
                    vec_exp.push_back(e);
                end else if (n > 0) begin
                    $display("malformed vector line: %s", line);
                    abort_run();
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic add_random_vectors(input int count);
        logic [31:0]       mode;
        logic [31:0]       flags;
        div_pkg::div_req_t r;
        for (int i = 0; i < count; i++) begin
            mode       = take_bits(2);
            r.dividend = take_bits(32);
            case (mode[1:0])
                2'd0:    r.divisor = take_bits(32);
                2'd1:    r.divisor = take_bits(16);
                2'd2:    r.divisor = take_bits(4);    // small, many quotient bits
                default: r.divisor = '0;
            endcase
            flags       = take_bits(2);
            r.is_signed = flags[1];
            r.want_rem  = flags[0];
            vec_req.push_back(r);
            vec_exp.push_back(ref_result(r));
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (timeout_limit != 0 && cycle_count > timeout_limit) begin
            $display("timeout after %0d cycles, %0d of %0d results arrived",
                     cycle_count, results_seen, vec_req.size());
            abort_run();
        end
    end

    // outputs settle after the rising edge, sample on the falling one
    always @(negedge clk) begin
        if (rstn) begin
            if ($isunknown(out_valid)) begin
                $display("out_valid is unknown after reset");
                abort_run();
            end else if (out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("out_valid went high with no request in flight");
                    abort_run();
                end else begin
                    check_data("out_data", out_data, exp_q.pop_front());
                    check_latency(cycle_count - issue_q.pop_front());
                    results_seen++;
                end
            end
        end
    end

    initial begin
        in_valid = 1'b0;
        in_req   = '0;

        load_vectors();
        add_random_vectors(RANDOM_COUNT);
        timeout_limit = vec_req.size() + `DIV_LATENCY + 20;

        wait (rstn === 1'b1);

        // back to back, one request per cycle
        foreach (vec_req[i]) begin
            @(negedge clk);
            in_valid = 1'b1;
            in_req   = vec_req[i];
            exp_q.push_back(vec_exp[i]);
            issue_q.push_back(cycle_count);
        end
        @(negedge clk);
        in_valid = 1'b0;
        in_req   = '0;

        while (results_seen < vec_req.size()) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);           // nothing extra may come out

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== verif/div_input.txt ====
# dividend divisor signed want_rem expected, all hex
# signed 1 selects div/rem, want_rem 1 selects the remainder
00000064 00000007 0 0 0000000e
00000064 00000007 0 1 00000002
ffffffff 00000001 0 0 ffffffff
ffffffff 00000010 0 0 0fffffff
ffffffff 00000010 0 1 0000000f
fffffff9 00000002 0 0 7ffffffc
fffffff9 00000002 0 1 00000001
80000000 ffffffff 0 0 00000000
80000000 ffffffff 0 1 80000000
00000005 0000000a 0 1 00000005
00000007 00000002 1 0 00000003
00000007 00000002 1 1 00000001
fffffff9 00000002 1 0 fffffffd
fffffff9 00000002 1 1 ffffffff
00000007 fffffffe 1 0 fffffffd
00000007 fffffffe 1 1 00000001
fffffff9 fffffffe 1 0 00000003
fffffff9 fffffffe 1 1 ffffffff
0001e240 000003e8 1 0 0000007b
0001e240 000003e8 1 1 000001c8
fffe1dc0 000003e8 1 0 ffffff85
fffe1dc0 000003e8 1 1 fffffe38
7fffffff 80000000 1 0 00000000
7fffffff 80000000 1 1 7fffffff
80000000 80000000 1 0 00000001
00000000 00000005 1 0 00000000
12345678 00000000 0 0 ffffffff
12345678 00000000 0 1 12345678
80000000 00000000 1 0 ffffffff
80000000 00000000 1 1 80000000
fffffff9 00000000 1 1 fffffff9
80000000 ffffffff 1 0 80000000
80000000 ffffffff 1 1 00000000

// ==== verilog.f ====
+incdir+source
source/div_pkg.sv
source/div_operand_prep.sv
source/div_cell.sv
source/div_array.sv
source/div_result_fix.sv
source/div_unit.sv
verif/div_clk_gen.sv
verif/tb_div_unit.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_div_unit
FILELIST  = verilog.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)
PASS_MSG  = TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# status comes from the search for the pass message
run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
